// File: Makefile
# Verilator build and run for the DQLA register I/O core
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_dqla_io
FILELIST  ?= dqla_io.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
EXE       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides
run: $(EXE)
	./$(EXE) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run ended without a verdict, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dqla_io.f
hdl/dqla_pkg.sv
hdl/reg_bus_if.sv
hdl/quad_encoder.sv
hdl/motor_channel.sv
hdl/board_regs.sv
hdl/dqla_io.sv
tb/tb_dqla_io.sv

// File: hdl/board_regs.sv
`timescale 1ns/10ps
`default_nettype none

module board_regs (
    input  logic                              sysclk,
    input  logic                              arst_n,
    reg_bus_if.target                         bus,
    input  dqla_pkg::board_id_t               board_id,
    input  logic                              wdog_timeout,
    input  logic [dqla_pkg::NUM_AXES-1:0]     home,
    input  logic [dqla_pkg::NUM_AXES-1:0]     neg_limit,
    input  logic [dqla_pkg::NUM_AXES-1:0]     pos_limit,
    output logic                              pwr_enable,
    output logic                              relay_on,
    output logic [dqla_pkg::NUM_AXES-1:0]     dout,
    output logic                              pwr_enable_cmd,
    output dqla_pkg::data_t                   rdata
);
    import dqla_pkg::*;

    logic wr_status;
    logic wr_dout;
    data_t status_word;
    data_t digin_word;

    assign wr_status = bus.wen && addr_match(bus.waddr, chan_t'(0), REG_STATUS);
    assign wr_dout   = bus.wen && addr_match(bus.waddr, chan_t'(0), REG_DIGOUT);

    // Host turning power on, used to clear the watchdog
    assign pwr_enable_cmd = wr_status && bus.wdata[PWR_EN_MASK_BIT] && bus.wdata[PWR_EN_BIT];

    // ----------------------------------------
    // Power and safety relay, masked writes
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_enable <= 1'b0;
            relay_on   <= 1'b0;
        end else begin
            if (wdog_timeout) begin
                pwr_enable <= 1'b0;           // Timeout drops board power
            end else if (wr_status && bus.wdata[PWR_EN_MASK_BIT]) begin
                pwr_enable <= bus.wdata[PWR_EN_BIT];
            end
            if (wr_status && bus.wdata[RELAY_MASK_BIT]) begin
                relay_on <= bus.wdata[RELAY_BIT];
            end
        end
    end

    // Digital outputs
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else if (wr_dout) begin
            dout <= bus.wdata[NUM_AXES-1:0];
        end
    end

    // ----------------------------------------
    // Read words
    // ----------------------------------------
    always_comb begin
        status_word = '0;
        status_word[BOARD_ID_LSB +: $bits(board_id_t)] = board_id;
        status_word[WDOG_BIT]   = wdog_timeout;
        status_word[PWR_EN_BIT] = pwr_enable;
        status_word[RELAY_BIT]  = relay_on;
    end

    assign digin_word = data_t'({home, neg_limit, pos_limit});   // 23:16, 15:8, 7:0

    always_comb begin
        case (offset_of(bus.raddr))
            REG_STATUS: rdata = status_word;
            REG_DIGIN:  rdata = digin_word;
            REG_DIGOUT: rdata = data_t'(dout);
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/dqla_io.sv
`timescale 1ns/10ps
`default_nettype none

module dqla_io (
    input  logic                          sysclk,
    input  logic                          arst_n,

    // Host register bus
    input  dqla_pkg::addr_t               reg_raddr,
    input  dqla_pkg::addr_t               reg_waddr,
    input  dqla_pkg::data_t               reg_wdata,
    input  logic                          reg_wen,
    output dqla_pkg::data_t               reg_rdata,   // One cycle after reg_raddr

    // Board pins
    input  dqla_pkg::board_id_t           board_id,
    input  logic [dqla_pkg::NUM_AXES-1:0] enc_a,
    input  logic [dqla_pkg::NUM_AXES-1:0] enc_b,
    input  logic [dqla_pkg::NUM_AXES-1:0] amp_fault,
    input  logic [dqla_pkg::NUM_AXES-1:0] home,
    input  logic [dqla_pkg::NUM_AXES-1:0] neg_limit,
    input  logic [dqla_pkg::NUM_AXES-1:0] pos_limit,
    input  logic                          wdog_timeout,
    output logic [dqla_pkg::NUM_AXES-1:0] amp_disable,
    output logic [dqla_pkg::NUM_AXES-1:0] dout,
    output logic                          relay_on,
    output logic                          dac_load,    // DAC chain update request
    output logic                          wdog_clear   // Clears the host watchdog
);
    import dqla_pkg::*;

    reg_bus_if bus ();

    logic                pwr_enable;
    logic                pwr_enable_cmd;
    logic [NUM_AXES-1:0] cur_written;
    logic [NUM_AXES-1:0] amp_enable_cmd;
    data_t               chan_rd [0:NUM_AXES];    // Index = channel number
    data_t               enc_rd  [1:NUM_AXES];
    data_t               mot_rd  [1:NUM_AXES];
    data_t               rd_mux;

    // Host side of the internal bus
    assign bus.waddr = reg_waddr;
    assign bus.wdata = reg_wdata;
    assign bus.wen   = reg_wen;
    assign bus.raddr = reg_raddr;

    // ----------------------------------------
    // Channel 0, board registers
    // ----------------------------------------
    board_regs u_board (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .bus            (bus),
        .board_id       (board_id),
        .wdog_timeout   (wdog_timeout),
        .home           (home),
        .neg_limit      (neg_limit),
        .pos_limit      (pos_limit),
        .pwr_enable     (pwr_enable),
        .relay_on       (relay_on),
        .dout           (dout),
        .pwr_enable_cmd (pwr_enable_cmd),
        .rdata          (chan_rd[0])
    );

    // ----------------------------------------
    // Channels 1..8, one motor and one encoder each
    // ----------------------------------------
    for (genvar k = 1; k <= NUM_AXES; k++) begin : g_axis
        motor_channel #(.CHANNEL(k)) u_motor (
            .sysclk         (sysclk),
            .arst_n         (arst_n),
            .bus            (bus),
            .pwr_enable     (pwr_enable),
            .wdog_timeout   (wdog_timeout),
            .amp_fault      (amp_fault[k-1]),
            .amp_disable    (amp_disable[k-1]),
            .cur_written    (cur_written[k-1]),
            .amp_enable_cmd (amp_enable_cmd[k-1]),
            .rdata          (mot_rd[k])
        );

        quad_encoder #(.CHANNEL(k)) u_enc (
            .sysclk (sysclk),
            .arst_n (arst_n),
            .bus    (bus),
            .enc_a  (enc_a[k-1]),
            .enc_b  (enc_b[k-1]),
            .rdata  (enc_rd[k])
        );

        // Offsets never overlap between motor and encoder
        assign chan_rd[k] = enc_rd[k] | mot_rd[k];
    end

    // ----------------------------------------
    // Read mux and output register
    // ----------------------------------------
    always_comb begin
        rd_mux = '0;                          // Other regions, channels 9..15
        if (region_of(reg_raddr) == ADDR_MAIN && int'(chan_of(reg_raddr)) <= NUM_AXES) begin
            rd_mux = chan_rd[chan_of(reg_raddr)];
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_mux;
        end
    end

    // Strobes, one cycle after the write
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_load   <= 1'b0;
            wdog_clear <= 1'b0;
        end else begin
            dac_load   <= |cur_written;
            wdog_clear <= pwr_enable_cmd || (|amp_enable_cmd);   // Power or any amp on
        end
    end

endmodule

`default_nettype wire

// File: hdl/dqla_pkg.sv
`default_nettype none

package dqla_pkg;

    // ----------------------------------------
    // Board geometry and bus widths
    // ----------------------------------------
    localparam int NUM_AXES = 8;              // Two quads of four axes

    typedef logic [15:0] addr_t;              // Host register address
    typedef logic [31:0] data_t;              // Host register data
    typedef logic [3:0]  region_t;            // addr[15:12]
    typedef logic [3:0]  chan_t;              // addr[7:4], 0 = board block
    typedef logic [3:0]  offset_t;            // addr[3:0]
    typedef logic [15:0] cur_cmd_t;           // Commanded motor current
    typedef logic [23:0] enc_count_t;         // Quadrature count
    typedef logic [3:0]  board_id_t;          // Rotary switch

    // Gray phases of the {a, b} pair, a leads b going forward
    typedef enum logic [1:0] {
        ENC_PH_00 = 2'b00,
        ENC_PH_10 = 2'b10,
        ENC_PH_11 = 2'b11,
        ENC_PH_01 = 2'b01
    } enc_state_t;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam region_t ADDR_MAIN = 4'd0;

    localparam offset_t REG_STATUS = 4'd0;    // Channel 0 only
    localparam offset_t REG_DIGIN  = 4'd1;
    localparam offset_t REG_DIGOUT = 4'd2;

    localparam offset_t OFF_DAC_CTRL     = 4'd1;   // Axis channels 1..8
    localparam offset_t OFF_ENC_LOAD     = 4'd4;
    localparam offset_t OFF_ENC_DATA     = 4'd5;
    localparam offset_t OFF_MOTOR_STATUS = 4'd12;

    // Status word bits
    localparam int RELAY_BIT       = 16;
    localparam int RELAY_MASK_BIT  = 17;
    localparam int PWR_EN_BIT      = 18;
    localparam int PWR_EN_MASK_BIT = 19;
    localparam int WDOG_BIT        = 23;
    localparam int BOARD_ID_LSB    = 24;      // board_id in 27:24

    // Motor status word bits
    localparam int AMP_EN_BIT      = 0;
    localparam int AMP_FAULT_BIT   = 16;
    localparam int AMP_DISABLE_BIT = 17;

    // Address fields, one decode shared by every target
    function automatic region_t region_of(addr_t a);
        return a[15:12];
    endfunction

    function automatic chan_t chan_of(addr_t a);
        return a[7:4];
    endfunction

    function automatic offset_t offset_of(addr_t a);
        return a[3:0];
    endfunction

    // True when the address hits one register of one channel in the main region
    function automatic logic addr_match(addr_t a, chan_t c, offset_t o);
        return (region_of(a) == ADDR_MAIN) && (chan_of(a) == c) && (offset_of(a) == o);
    endfunction

endpackage

`default_nettype wire

// File: hdl/motor_channel.sv
`timescale 1ns/10ps
`default_nettype none

module motor_channel #(
    parameter int CHANNEL = 1                 // 1..NUM_AXES
) (
    input  logic            sysclk,
    input  logic            arst_n,
    reg_bus_if.target       bus,
    input  logic            pwr_enable,       // Board power from channel 0
    input  logic            wdog_timeout,
    input  logic            amp_fault,
    output logic            amp_disable,      // To the amplifier pin
    output logic            cur_written,      // Same-cycle strobe
    output logic            amp_enable_cmd,   // Host asked to enable
    output dqla_pkg::data_t rdata
);
    import dqla_pkg::*;

    logic     wr_dac;
    logic     wr_status;
    logic     amp_en;
    logic     amp_en_next;
    cur_cmd_t cur_cmd;

    assign wr_dac    = bus.wen && addr_match(bus.waddr, chan_t'(CHANNEL), OFF_DAC_CTRL);
    assign wr_status = bus.wen && addr_match(bus.waddr, chan_t'(CHANNEL), OFF_MOTOR_STATUS);

    assign cur_written    = wr_dac;
    assign amp_enable_cmd = wr_status && bus.wdata[AMP_EN_BIT];   // Even while blocked

    // ----------------------------------------
    // Commanded current
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else if (wr_dac) begin
            cur_cmd <= bus.wdata[$bits(cur_cmd_t)-1:0];
        end
    end

    // ----------------------------------------
    // Amplifier enable
    // ----------------------------------------
    always_comb begin
        amp_en_next = amp_en;
        if (!pwr_enable || wdog_timeout) begin
            amp_en_next = 1'b0;               // Safety wins over any write
        end else if (wr_status) begin
            amp_en_next = bus.wdata[AMP_EN_BIT];
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            amp_en      <= 1'b0;
            amp_disable <= 1'b1;              // Amplifier off out of reset
        end else begin
            amp_en      <= amp_en_next;
            amp_disable <= ~amp_en_next;
        end
    end

    // Read word for this axis
    always_comb begin
        rdata = '0;
        case (offset_of(bus.raddr))
            OFF_DAC_CTRL: rdata = data_t'(cur_cmd);
            OFF_MOTOR_STATUS: begin
                rdata[AMP_EN_BIT]      = amp_en;
                rdata[AMP_FAULT_BIT]   = amp_fault;
                rdata[AMP_DISABLE_BIT] = amp_disable;
            end
            default: rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/quad_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module quad_encoder #(
    parameter int CHANNEL = 1                 // 1..NUM_AXES
) (
    input  logic            sysclk,
    input  logic            arst_n,
    reg_bus_if.target       bus,
    input  logic            enc_a,
    input  logic            enc_b,
    output dqla_pkg::data_t rdata
);
    import dqla_pkg::*;

    logic [1:0] a_sync;                       // [1] is the synchronized copy
    logic [1:0] b_sync;
    enc_state_t phase;                        // Last phase seen
    enc_state_t phase_in;                     // Phase from the synchronizers
    logic       step_fwd;
    logic       step_rev;
    logic       load_hit;
    enc_count_t preload;
    enc_count_t count;

    // Forward successor in the Gray cycle 00 -> 10 -> 11 -> 01
    function automatic enc_state_t next_fwd(enc_state_t s);
        case (s)
            ENC_PH_00: return ENC_PH_10;
            ENC_PH_10: return ENC_PH_11;
            ENC_PH_11: return ENC_PH_01;
            default:   return ENC_PH_00;
        endcase
    endfunction

    // ----------------------------------------
    // Input synchronizers, two stages
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            a_sync <= '0;
            b_sync <= '0;
        end else begin
            a_sync <= {a_sync[0], enc_a};
            b_sync <= {b_sync[0], enc_b};
        end
    end

    assign phase_in = enc_state_t'({a_sync[1], b_sync[1]});

    // Single Gray steps only; a two-phase jump matches neither
    assign step_fwd = (phase_in == next_fwd(phase));
    assign step_rev = (phase == next_fwd(phase_in));

    assign load_hit = bus.wen && addr_match(bus.waddr, chan_t'(CHANNEL), OFF_ENC_LOAD);

    // ----------------------------------------
    // Phase tracking and 4x count
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= ENC_PH_00;
            preload <= '0;
            count   <= '0;
        end else begin
            phase <= phase_in;
            if (load_hit) begin                // Preload beats a step
                preload <= bus.wdata[$bits(enc_count_t)-1:0];
                count   <= bus.wdata[$bits(enc_count_t)-1:0];
            end else if (step_fwd) begin
                count <= count + 1'b1;
            end else if (step_rev) begin
                count <= count - 1'b1;        // Wraps modulo 2^24
            end
        end
    end

    // Read word, channel select is done at the top
    always_comb begin
        case (offset_of(bus.raddr))
            OFF_ENC_LOAD: rdata = data_t'(preload);   // Zero-extended
            OFF_ENC_DATA: rdata = data_t'(count);
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface reg_bus_if;
    import dqla_pkg::*;

    addr_t waddr;       // Write address
    data_t wdata;       // Write data
    logic  wen;         // Single-cycle write strobe, no back-pressure
    addr_t raddr;       // Read address, data comes back per target

    // Top level drives the bus from its pins
    modport host (
        output waddr,
        output wdata,
        output wen,
        output raddr
    );

    // Board block, motor channels and encoders
    modport target (
        input waddr,
        input wdata,
        input wen,
        input raddr
    );

endinterface

`default_nettype wire

// File: tb/tb_dqla_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dqla_io;
    import dqla_pkg::*;

    localparam int STROBE_TIMEOUT = 20;       // Cycles per strobe wait

    logic sysclk;
    logic arst_n;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic reg_wen;
    logic [31:0] reg_rdata;
    logic [3:0] board_id;
    logic [7:0] enc_a;
    logic [7:0] enc_b;
    logic [7:0] amp_fault;
    logic [7:0] home;
    logic [7:0] neg_limit;
    logic [7:0] pos_limit;
    logic wdog_timeout;
    logic [7:0] amp_disable;
    logic [7:0] dout;
    logic relay_on;
    logic dac_load;
    logic wdog_clear;

    // Reference model with axis arrays indexed by channel number
    logic [15:0] cmd_model     [1:8];
    logic        amp_en_model  [1:8];
    logic [23:0] preload_model [1:8];
    logic [23:0] count_model   [1:8];
    logic [1:0]  phase_model   [1:8];     // {a, b} last driven
    logic        pwr_model;
    logic        relay_model;
    logic [7:0]  dout_model;

    // Hand-off from the read task to the checker
    event        read_done;
    string       rd_name;
    logic [31:0] rd_exp;
    logic [31:0] rd_got;
    int          read_count;
    int          fail_count;
    int unsigned seed_val;
    int          n_fwd;
    int          n_rev;

    dqla_io dqla_io_inst (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .reg_rdata    (reg_rdata),
        .board_id     (board_id),
        .enc_a        (enc_a),
        .enc_b        (enc_b),
        .amp_fault    (amp_fault),
        .home         (home),
        .neg_limit    (neg_limit),
        .pos_limit    (pos_limit),
        .wdog_timeout (wdog_timeout),
        .amp_disable  (amp_disable),
        .dout         (dout),
        .relay_on     (relay_on),
        .dac_load     (dac_load),
        .wdog_clear   (wdog_clear)
    );

    always #5 sysclk = ~sysclk;               // 100 MHz

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_count++;
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Checker compares once per completed read
    always @(read_done) check_value(rd_name, rd_exp, rd_got);

    function automatic logic [15:0] reg_addr(input logic [3:0] region, input logic [3:0] chan,
                                             input logic [3:0] off);
        return {region, 4'h0, chan, off};
    endfunction

    // ----------------------------------------
    // Expected read word from the model
    // ----------------------------------------
    function automatic logic [31:0] expected_read(input logic [15:0] addr);
        logic [31:0] w;
        int          ch;
        w  = '0;
        ch = int'(addr[7:4]);
        if (addr[15:12] == ADDR_MAIN && ch == 0) begin
            case (addr[3:0])
                REG_STATUS: begin
                    w[BOARD_ID_LSB +: 4] = board_id;
                    w[WDOG_BIT]          = wdog_timeout;
                    w[PWR_EN_BIT]        = pwr_model;
                    w[RELAY_BIT]         = relay_model;
                end
                REG_DIGIN:  w = {8'h00, home, neg_limit, pos_limit};
                REG_DIGOUT: w = {24'h0, dout_model};
                default:    w = '0;
            endcase
        end else if (addr[15:12] == ADDR_MAIN && ch <= 8) begin
            case (addr[3:0])
                OFF_DAC_CTRL: w = {16'h0, cmd_model[ch]};
                OFF_ENC_LOAD: w = {8'h0, preload_model[ch]};
                OFF_ENC_DATA: w = {8'h0, count_model[ch]};
                OFF_MOTOR_STATUS: begin
                    w[AMP_EN_BIT]      = amp_en_model[ch];
                    w[AMP_FAULT_BIT]   = amp_fault[ch-1];
                    w[AMP_DISABLE_BIT] = ~amp_en_model[ch];
                end
                default: w = '0;
            endcase
        end
        return w;                             // Zero for other regions and channels 9..15
    endfunction

    // Register effects of a host write
    task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
        int ch;
        ch = int'(addr[7:4]);
        if (addr[15:12] == ADDR_MAIN && ch == 0) begin
            if (addr[3:0] == REG_STATUS) begin
                if (data[PWR_EN_MASK_BIT] && !wdog_timeout) pwr_model = data[PWR_EN_BIT];
                if (data[RELAY_MASK_BIT]) relay_model = data[RELAY_BIT];
            end else if (addr[3:0] == REG_DIGOUT) begin
                dout_model = data[7:0];
            end
        end else if (addr[15:12] == ADDR_MAIN && ch >= 1 && ch <= 8) begin
            if (addr[3:0] == OFF_DAC_CTRL) cmd_model[ch] = data[15:0];
            if (addr[3:0] == OFF_MOTOR_STATUS && pwr_model && !wdog_timeout)
                amp_en_model[ch] = data[AMP_EN_BIT];
            if (addr[3:0] == OFF_ENC_LOAD) begin
                preload_model[ch] = data[23:0];
                count_model[ch]   = data[23:0];   // Count follows the preload
            end
        end
    endtask

    // ----------------------------------------
    // Host bus tasks called 1 ns after an edge
    // ----------------------------------------
    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(posedge sysclk);
        #1;
        reg_wen = 1'b0;                       // Single-cycle strobe
        model_write(addr, data);
    endtask

    task automatic bus_read(input logic [15:0] addr);
        logic [31:0] exp;
        reg_raddr = addr;
        exp       = expected_read(addr);      // State before the sampling edge
        @(posedge sysclk);
        #1;
        rd_name = $sformatf("reg_rdata @%h", addr);
        rd_exp  = exp;
        rd_got  = reg_rdata;
        read_count++;
        -> read_done;
    endtask

    // Bounded wait for the one-cycle strobe after a write
    task automatic expect_pulse(input bit use_wdog, input string name);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < STROBE_TIMEOUT) begin
            if ((use_wdog ? wdog_clear : dac_load) === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge sysclk);
                #1;
                n++;
            end
        end
        if (!seen) begin
            $display("No %s pulse seen within %0d cycles", name, STROBE_TIMEOUT);
            $display("SIMULATION FAILED");
            $fatal(1, "strobe timeout");
        end
        check_value({name, " delay"}, 32'd0, 32'(n));
        @(posedge sysclk);
        #1;
        check_value({name, " width"}, 32'd0, 32'(use_wdog ? wdog_clear : dac_load));
    endtask

    // Gray step on one axis held for 4 cycles
    task automatic enc_step(input int k, input bit fwd, input bit jump);
        logic [1:0] nxt;
        case (phase_model[k])                 // Forward 00 -> 10 -> 11 -> 01
            2'b00:   nxt = fwd ? 2'b10 : 2'b01;
            2'b10:   nxt = fwd ? 2'b11 : 2'b00;
            2'b11:   nxt = fwd ? 2'b01 : 2'b10;
            default: nxt = fwd ? 2'b00 : 2'b11;
        endcase
        if (jump) nxt = phase_model[k] ^ 2'b11;   // Skipped phase leaves the count
        else count_model[k] = fwd ? count_model[k] + 24'd1 : count_model[k] - 24'd1;
        phase_model[k] = nxt;
        enc_a[k-1]     = nxt[1];
        enc_b[k-1]     = nxt[0];
        repeat (4) begin
            @(posedge sysclk);
            #1;
        end
    endtask

    initial begin
        sysclk       = 1'b0;
        arst_n       = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        enc_a        = '0;
        enc_b        = '0;
        amp_fault    = '0;
        wdog_timeout = 1'b0;
        home         = '0;
        neg_limit    = '0;
        pos_limit    = '0;
        seed_val     = $urandom(80886);
        board_id     = 4'(seed_val % 15) + 4'd1;   // Nonzero so the id field shows
        pwr_model    = 1'b0;
        relay_model  = 1'b0;
        dout_model   = '0;
        read_count   = 0;
        fail_count   = 0;
        for (int k = 1; k <= 8; k++) begin
            cmd_model[k]     = '0;
            amp_en_model[k]  = 1'b0;
            phase_model[k]   = 2'b00;
            preload_model[k] = '0;
            count_model[k]   = '0;
        end
        repeat (10) @(posedge sysclk);
        #1;
        arst_n = 1'b1;

        // ----------------------------------------
        // Reset values, id and unmapped reads
        // ----------------------------------------
        check_value("amp_disable", 32'hFF, 32'(amp_disable));
        check_value("dout", 32'h0, 32'(dout));
        check_value("relay_on", 32'h0, 32'(relay_on));
        bus_read(reg_addr(4'h0, 4'h0, REG_STATUS));
        bus_read(reg_addr(4'h0, 4'h0, REG_DIGOUT));
        for (int c = 9; c <= 15; c++) begin
            bus_read(reg_addr(4'h0, 4'(c), REG_STATUS));
            bus_read(reg_addr(4'h0, 4'(c), OFF_MOTOR_STATUS));   // Axis words are nonzero
        end
        for (int r = 1; r <= 15; r++) bus_read(reg_addr(4'(r), 4'h0, REG_STATUS));

        // One dac_load per commanded current write
        for (int k = 1; k <= 8; k++) begin
            bus_write(reg_addr(4'h0, 4'(k), OFF_DAC_CTRL), $urandom);
            expect_pulse(1'b0, "dac_load");
            bus_read(reg_addr(4'h0, 4'(k), OFF_DAC_CTRL));
        end

        // ----------------------------------------
        // Power, relay and amplifier enables
        // ----------------------------------------
        bus_write(reg_addr(4'h0, 4'h0, REG_STATUS), 32'h000F_0000);   // Power and relay on
        expect_pulse(1'b1, "wdog_clear");
        bus_write(reg_addr(4'h0, 4'h0, REG_STATUS), 32'h000C_0000);   // Relay masked off
        expect_pulse(1'b1, "wdog_clear");
        bus_read(reg_addr(4'h0, 4'h0, REG_STATUS));
        check_value("relay_on", 32'(relay_model), 32'(relay_on));
        for (int k = 1; k <= 8; k += 2) begin
            bus_write(reg_addr(4'h0, 4'(k), OFF_MOTOR_STATUS), 32'h1);
            expect_pulse(1'b1, "wdog_clear");
        end
        check_value("amp_disable", 32'hAA, 32'(amp_disable));
        for (int k = 1; k <= 8; k++) bus_read(reg_addr(4'h0, 4'(k), OFF_MOTOR_STATUS));

        wdog_timeout = 1'b1;
        @(posedge sysclk);
        #1;
        pwr_model = 1'b0;                     // Timeout drops power and every axis
        for (int k = 1; k <= 8; k++) amp_en_model[k] = 1'b0;
        check_value("amp_disable", 32'hFF, 32'(amp_disable));
        bus_write(reg_addr(4'h0, 4'h2, OFF_MOTOR_STATUS), 32'h1);      // Blocked enable
        expect_pulse(1'b1, "wdog_clear");
        bus_read(reg_addr(4'h0, 4'h0, REG_STATUS));
        for (int k = 1; k <= 8; k++) bus_read(reg_addr(4'h0, 4'(k), OFF_MOTOR_STATUS));
        wdog_timeout = 1'b0;
        bus_read(reg_addr(4'h0, 4'h0, REG_STATUS));

        // ----------------------------------------
        // Encoder preload then Gray steps
        // ----------------------------------------
        for (int k = 1; k <= 8; k++) begin
            bus_write(reg_addr(4'h0, 4'(k), OFF_ENC_LOAD), $urandom);
            bus_read(reg_addr(4'h0, 4'(k), OFF_ENC_LOAD));
            n_fwd = 3 + int'($urandom % 6);
            n_rev = int'($urandom % 5);
            repeat (n_fwd) enc_step(k, 1'b1, 1'b0);
            repeat (n_rev) enc_step(k, 1'b0, 1'b0);
            bus_read(reg_addr(4'h0, 4'(k), OFF_ENC_DATA));
            enc_step(k, 1'b1, 1'b1);
            bus_read(reg_addr(4'h0, 4'(k), OFF_ENC_DATA));
        end

        // Digital inputs, faults and outputs
        repeat (4) begin
            home      = 8'($urandom);
            neg_limit = 8'($urandom);
            pos_limit = 8'($urandom);
            amp_fault = 8'($urandom);
            bus_read(reg_addr(4'h0, 4'h0, REG_DIGIN));
            for (int k = 1; k <= 8; k++) bus_read(reg_addr(4'h0, 4'(k), OFF_MOTOR_STATUS));
            bus_write(reg_addr(4'h0, 4'h0, REG_DIGOUT), $urandom);
            check_value("dout", 32'(dout_model), 32'(dout));
            bus_read(reg_addr(4'h0, 4'h0, REG_DIGOUT));
        end

        repeat (5) @(posedge sysclk);       // Let the last compare finish
        $display("%0d reads compared", read_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
